/* logic/fetch_params.svh */
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// --------------------------------------------------
// frontend sizing
// --------------------------------------------------

// fetch and target address width
`define FE_ADDR_W 32

// branch history table, indexed from pc bit 2 up
`define FE_BHT_ENTRIES 16

// branch target buffer for jalr, full pc tag
`define FE_BTB_ENTRIES 8

// instruction queue depth toward the back-end
`define FE_QUEUE_DEPTH 4

`endif

/* logic/fetch_pkg.sv */
`include "fetch_params.svh"

package fetch_pkg;

    // --------------------------------------------------
    // scalar types
    // --------------------------------------------------
    typedef logic [`FE_ADDR_W-1:0] addr_t;
    typedef logic [31:0]           instr_t;

    // control-flow kind found by the scan
    typedef enum logic [1:0] {
        CF_NONE   = 2'd0,
        CF_BRANCH = 2'd1,
        CF_JUMP   = 2'd2,
        CF_JALR   = 2'd3
    } cf_e;

    // memory request state
    // drop means the outstanding response is stale
    typedef enum logic [1:0] {
        FETCH_IDLE = 2'd0,
        FETCH_WAIT = 2'd1,
        FETCH_DROP = 2'd2
    } fetch_state_e;

    // --------------------------------------------------
    // bundles
    // --------------------------------------------------
    // one queued instruction with its prediction
    typedef struct packed {
        addr_t  pc;
        instr_t instr;
        cf_e    cf;
        logic   taken;
        addr_t  predict_addr;
    } fetch_entry_t;

    // resolution from the back-end, trains the predictor
    typedef struct packed {
        logic  valid;
        addr_t pc;
        addr_t target;
        cf_e   cf;
        logic  taken;
        logic  mispredict;
    } resolve_t;

    typedef struct packed {
        cf_e   cf;
        addr_t imm;
    } scan_t;

endpackage

/* logic/fetch_ctrl.sv */
module fetch_ctrl (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  fetch_pkg::addr_t        boot_addr_i,
    output logic                    imem_req_o,
    output fetch_pkg::addr_t        imem_addr_o,
    input  logic                    imem_gnt_i,
    input  logic                    imem_rvalid_i,
    input  fetch_pkg::instr_t       imem_rdata_i,
    input  logic                    room_i,
    input  fetch_pkg::resolve_t     resolve_i,
    input  logic                    eret_i,
    input  fetch_pkg::addr_t        epc_i,
    input  logic                    ex_valid_i,
    input  fetch_pkg::addr_t        trap_vector_i,
    input  fetch_pkg::addr_t        next_pc_i,
    input  logic                    taken_i,
    input  fetch_pkg::cf_e          cf_i,
    output fetch_pkg::addr_t        resp_pc_o,
    output fetch_pkg::instr_t       resp_instr_o,
    output logic                    resp_valid_o,
    output logic                    push_o,
    output fetch_pkg::fetch_entry_t push_entry_o,
    output logic                    flush_o
);
    import fetch_pkg::*;

    fetch_state_e state_q, state_d;
    addr_t        pc_q, pc_d;
    logic         req_q, req_d;
    // set during reset, pc takes boot_addr_i on the first cycle out
    logic         boot_load_q;
    logic         redirect;
    addr_t        redirect_pc;
    logic         accept;

    // --------------------------------------------------
    // redirect priority: exception, eret, mispredict
    // --------------------------------------------------
    always_comb begin
        redirect    = 1'b1;
        redirect_pc = resolve_i.target;
        if (ex_valid_i) begin
            redirect_pc = trap_vector_i;
        end else if (eret_i) begin
            redirect_pc = epc_i;
        end else if (!(resolve_i.valid && resolve_i.mispredict)) begin
            redirect = 1'b0;
        end
    end

    assign accept       = req_q & imem_gnt_i;
    // only a response in wait belongs to pc_q
    assign resp_valid_o = (state_q == FETCH_WAIT) & imem_rvalid_i;
    assign resp_pc_o    = pc_q;
    assign resp_instr_o = imem_rdata_i;

    // --------------------------------------------------
    // request state machine and next pc
    // --------------------------------------------------
    always_comb begin
        state_d = state_q;
        req_d   = req_q;
        pc_d    = pc_q;
        case (state_q)
            FETCH_IDLE: begin
                if (accept) begin
                    req_d   = 1'b0;
                    // accepted in the redirect cycle, answer is stale
                    state_d = redirect ? FETCH_DROP : FETCH_WAIT;
                end else if (redirect) begin
                    // lower req for a cycle while the address moves
                    req_d = 1'b0;
                end else if (room_i) begin
                    req_d = 1'b1;
                end
            end
            FETCH_WAIT: begin
                if (imem_rvalid_i) begin
                    state_d = FETCH_IDLE;
                    pc_d    = next_pc_i;
                end else if (redirect) begin
                    state_d = FETCH_DROP;
                end
            end
            FETCH_DROP: begin
                // swallow the stale response
                if (imem_rvalid_i) begin
                    state_d = FETCH_IDLE;
                end
            end
            default: begin
                state_d = FETCH_IDLE;
            end
        endcase
        if (boot_load_q) begin
            pc_d = boot_addr_i;
        end
        // redirect overrides prediction and boot load
        if (redirect) begin
            pc_d = redirect_pc;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= FETCH_IDLE;
            req_q       <= 1'b0;
            pc_q        <= '0;
            boot_load_q <= 1'b1;
        end else begin
            state_q     <= state_d;
            req_q       <= req_d;
            pc_q        <= pc_d;
            boot_load_q <= 1'b0;
        end
    end

    assign imem_req_o  = req_q;
    assign imem_addr_o = pc_q;

    // --------------------------------------------------
    // queue push, one per live response
    // --------------------------------------------------
    assign push_o                    = resp_valid_o & ~redirect;
    assign push_entry_o.pc           = pc_q;
    assign push_entry_o.instr        = imem_rdata_i;
    assign push_entry_o.cf           = cf_i;
    assign push_entry_o.taken        = taken_i;
    assign push_entry_o.predict_addr = next_pc_i;
    assign flush_o                   = redirect;

endmodule

/* logic/instr_scan.sv */
`include "fetch_params.svh"

module instr_scan (
    input  fetch_pkg::instr_t instr_i,
    output fetch_pkg::scan_t  scan_o
);
    import fetch_pkg::*;

    // rv32i opcodes of interest
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    addr_t      imm_b;
    addr_t      imm_j;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];

    // --------------------------------------------------
    // immediates, sign-extended to address width
    // --------------------------------------------------
    // b-type, bit 0 always zero
    assign imm_b = {{(`FE_ADDR_W-12){instr_i[31]}}, instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    // j-type
    assign imm_j = {{(`FE_ADDR_W-20){instr_i[31]}}, instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    // --------------------------------------------------
    // classification
    // --------------------------------------------------
    always_comb begin
        scan_o.cf  = CF_NONE;
        scan_o.imm = '0;
        case (opcode)
            OPC_BRANCH: begin
                // funct3 010 and 011 are reserved encodings
                if (funct3[2:1] != 2'b01) begin
                    scan_o.cf  = CF_BRANCH;
                    scan_o.imm = imm_b;
                end
            end
            OPC_JAL: begin
                scan_o.cf  = CF_JUMP;
                scan_o.imm = imm_j;
            end
            OPC_JALR: begin
                // target comes from the btb, imm stays zero
                if (funct3 == 3'b000) begin
                    scan_o.cf = CF_JALR;
                end
            end
            default: ;
        endcase
    end

endmodule

/* logic/branch_predictor.sv */
`include "fetch_params.svh"

module branch_predictor #(
    parameter int unsigned BHT_ENTRIES = `FE_BHT_ENTRIES,
    parameter int unsigned BTB_ENTRIES = `FE_BTB_ENTRIES
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  fetch_pkg::addr_t    pc_i,
    input  logic                valid_i,
    input  fetch_pkg::scan_t    scan_i,
    input  fetch_pkg::resolve_t resolve_i,
    output logic                taken_o,
    output fetch_pkg::addr_t    next_pc_o
);
    import fetch_pkg::*;

    localparam int unsigned BHT_IDX_W = $clog2(BHT_ENTRIES);
    localparam int unsigned BTB_IDX_W = $clog2(BTB_ENTRIES);

    // history table, valid bit plus 2-bit counter
    logic [BHT_ENTRIES-1:0] bht_valid_q;
    logic [1:0]             bht_cnt_q [BHT_ENTRIES];
    // target buffer, tagged with the full pc
    logic [BTB_ENTRIES-1:0] btb_valid_q;
    addr_t                  btb_tag_q [BTB_ENTRIES];
    addr_t                  btb_target_q [BTB_ENTRIES];

    logic [BHT_IDX_W-1:0]   bht_rd_idx, bht_wr_idx;
    logic [BTB_IDX_W-1:0]   btb_rd_idx, btb_wr_idx;
    logic                   bht_update, btb_update, btb_hit, predict_taken;
    logic [1:0]             bht_cnt_next;
    addr_t                  target;

    assign bht_rd_idx = pc_i[2 +: BHT_IDX_W];
    assign bht_wr_idx = resolve_i.pc[2 +: BHT_IDX_W];
    assign btb_rd_idx = pc_i[2 +: BTB_IDX_W];
    assign btb_wr_idx = resolve_i.pc[2 +: BTB_IDX_W];

    assign bht_update = resolve_i.valid & (resolve_i.cf == CF_BRANCH);
    // only a mispredicted jalr trains the btb
    assign btb_update = resolve_i.valid & resolve_i.mispredict & (resolve_i.cf == CF_JALR);
    assign btb_hit    = btb_valid_q[btb_rd_idx] & (btb_tag_q[btb_rd_idx] == pc_i);

    // --------------------------------------------------
    // lookup and next pc
    // --------------------------------------------------
    always_comb begin
        predict_taken = 1'b0;
        target        = pc_i + scan_i.imm;
        case (scan_i.cf)
            CF_BRANCH: begin
                // invalid entry falls back to backward taken
                predict_taken = bht_valid_q[bht_rd_idx] ? bht_cnt_q[bht_rd_idx][1]
                                                        : scan_i.imm[$bits(addr_t)-1];
            end
            CF_JUMP: predict_taken = 1'b1;
            CF_JALR: begin
                predict_taken = btb_hit;
                target        = btb_target_q[btb_rd_idx];
            end
            default: ;
        endcase
    end

    assign taken_o   = valid_i & predict_taken;
    assign next_pc_o = taken_o ? target : pc_i + addr_t'(4);

    // --------------------------------------------------
    // update from resolve
    // --------------------------------------------------
    always_comb begin
        bht_cnt_next = bht_cnt_q[bht_wr_idx];
        if (!bht_valid_q[bht_wr_idx]) begin
            // first sighting, weakly toward the outcome
            bht_cnt_next = resolve_i.taken ? 2'd2 : 2'd1;
        end else if (resolve_i.taken) begin
            if (bht_cnt_q[bht_wr_idx] != 2'd3) begin
                bht_cnt_next = bht_cnt_q[bht_wr_idx] + 2'd1;
            end
        end else if (bht_cnt_q[bht_wr_idx] != 2'd0) begin
            bht_cnt_next = bht_cnt_q[bht_wr_idx] - 2'd1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            bht_valid_q <= '0;
            btb_valid_q <= '0;
        end else begin
            if (bht_update) begin
                bht_valid_q[bht_wr_idx] <= 1'b1;
            end
            if (btb_update) begin
                btb_valid_q[btb_wr_idx] <= 1'b1;
            end
        end
    end

    // table contents, qualified by the valid bits above
    always_ff @(posedge clk_i) begin
        if (bht_update) begin
            bht_cnt_q[bht_wr_idx] <= bht_cnt_next;
        end
        if (btb_update) begin
            btb_tag_q[btb_wr_idx]    <= resolve_i.pc;
            btb_target_q[btb_wr_idx] <= resolve_i.target;
        end
    end

endmodule

/* logic/fetch_queue.sv */
`include "fetch_params.svh"

module fetch_queue #(
    parameter int unsigned DEPTH = `FE_QUEUE_DEPTH
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  logic                    push_i,
    input  fetch_pkg::fetch_entry_t entry_i,
    input  logic                    ready_i,
    output fetch_pkg::fetch_entry_t entry_o,
    output logic                    valid_o,
    output logic                    room_o
);
    import fetch_pkg::*;

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    fetch_entry_t     mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push, pop;

    // circular pointer step, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // head is visible as soon as it is written
    assign entry_o = mem_q[rd_ptr_q];
    assign valid_o = (count_q != '0);
    assign pop     = valid_o & ready_i;
    // flush wins over a push in the same edge
    assign push    = push_i & ~flush_i & (count_q != CNT_W'(DEPTH));
    // two free slots, one for the outstanding fetch and one spare
    assign room_o  = (CNT_W'(DEPTH) - count_q) >= CNT_W'(2);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= entry_i;
        end
    end

endmodule

/* logic/fetch_frontend.sv */
module fetch_frontend (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  fetch_pkg::addr_t        boot_addr_i,
    // instruction memory
    output logic                    imem_req_o,
    output fetch_pkg::addr_t        imem_addr_o,
    input  logic                    imem_gnt_i,
    input  logic                    imem_rvalid_i,
    input  fetch_pkg::instr_t       imem_rdata_i,
    // redirects from the back-end
    input  fetch_pkg::resolve_t     resolve_i,
    input  logic                    eret_i,
    input  fetch_pkg::addr_t        epc_i,
    input  logic                    ex_valid_i,
    input  fetch_pkg::addr_t        trap_vector_i,
    // entries to the back-end
    output fetch_pkg::fetch_entry_t fetch_entry_o,
    output logic                    fetch_entry_valid_o,
    input  logic                    fetch_entry_ready_i
);
    import fetch_pkg::*;

    // --------------------------------------------------
    // internal wires
    // --------------------------------------------------
    addr_t        resp_pc;
    instr_t       resp_instr;
    logic         resp_valid;
    scan_t        scan;
    logic         taken;
    addr_t        next_pc;
    logic         push;
    fetch_entry_t push_entry;
    logic         flush;
    logic         room;

    // pc, request fsm and redirect handling
    fetch_ctrl i_fetch_ctrl (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .boot_addr_i   ( boot_addr_i   ),
        .imem_req_o    ( imem_req_o    ),
        .imem_addr_o   ( imem_addr_o   ),
        .imem_gnt_i    ( imem_gnt_i    ),
        .imem_rvalid_i ( imem_rvalid_i ),
        .imem_rdata_i  ( imem_rdata_i  ),
        .room_i        ( room          ),
        .resolve_i     ( resolve_i     ),
        .eret_i        ( eret_i        ),
        .epc_i         ( epc_i         ),
        .ex_valid_i    ( ex_valid_i    ),
        .trap_vector_i ( trap_vector_i ),
        .next_pc_i     ( next_pc       ),
        .taken_i       ( taken         ),
        .cf_i          ( scan.cf       ),
        .resp_pc_o     ( resp_pc       ),
        .resp_instr_o  ( resp_instr    ),
        .resp_valid_o  ( resp_valid    ),
        .push_o        ( push          ),
        .push_entry_o  ( push_entry    ),
        .flush_o       ( flush         )
    );

    instr_scan i_instr_scan (
        .instr_i ( resp_instr ),
        .scan_o  ( scan       )
    );

    branch_predictor i_branch_predictor (
        .clk_i     ( clk_i      ),
        .rst_ni    ( rst_ni     ),
        .pc_i      ( resp_pc    ),
        .valid_i   ( resp_valid ),
        .scan_i    ( scan       ),
        .resolve_i ( resolve_i  ),
        .taken_o   ( taken      ),
        .next_pc_o ( next_pc    )
    );

    fetch_queue i_fetch_queue (
        .clk_i   ( clk_i               ),
        .rst_ni  ( rst_ni              ),
        .flush_i ( flush               ),
        .push_i  ( push                ),
        .entry_i ( push_entry          ),
        .ready_i ( fetch_entry_ready_i ),
        .entry_o ( fetch_entry_o       ),
        .valid_o ( fetch_entry_valid_o ),
        .room_o  ( room                )
    );

endmodule

/* verification/fetch_frontend_sva.sv */
module fetch_frontend_sva (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    imem_req_i,
    input  fetch_pkg::addr_t        imem_addr_i,
    input  logic                    imem_gnt_i,
    input  logic                    imem_rvalid_i,
    input  fetch_pkg::resolve_t     resolve_i,
    input  logic                    eret_i,
    input  logic                    ex_valid_i,
    input  fetch_pkg::fetch_entry_t fetch_entry_i,
    input  logic                    fetch_entry_valid_i,
    input  logic                    fetch_entry_ready_i
);
    import fetch_pkg::*;

    logic outstanding_q;
    logic redirect;

    // any redirect flushes the queue, so the head may legally vanish
    assign redirect = ex_valid_i | eret_i | (resolve_i.valid & resolve_i.mispredict);

    // one accepted request waiting for its rvalid
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            outstanding_q <= 1'b0;
        end else if (imem_req_i && imem_gnt_i) begin
            outstanding_q <= 1'b1;
        end else if (imem_rvalid_i) begin
            outstanding_q <= 1'b0;
        end
    end

    // --------------------------------------------------
    // memory side
    // --------------------------------------------------
    addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        imem_req_i && !imem_gnt_i |=> !imem_req_i || $stable(imem_addr_i))
        else $error("imem address moved while the request was pending");

    rvalid_after_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
        imem_rvalid_i |-> outstanding_q)
        else $error("rvalid without an accepted request");

    // --------------------------------------------------
    // back-end side
    // --------------------------------------------------
    entry_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fetch_entry_valid_i && !fetch_entry_ready_i && !redirect
        |=> fetch_entry_valid_i && $stable(fetch_entry_i))
        else $error("fetch entry changed while stalled");

endmodule

bind fetch_frontend fetch_frontend_sva i_fetch_frontend_sva (
    .clk_i               ( clk_i               ),
    .rst_ni              ( rst_ni              ),
    .imem_req_i          ( imem_req_o          ),
    .imem_addr_i         ( imem_addr_o         ),
    .imem_gnt_i          ( imem_gnt_i          ),
    .imem_rvalid_i       ( imem_rvalid_i       ),
    .resolve_i           ( resolve_i           ),
    .eret_i              ( eret_i              ),
    .ex_valid_i          ( ex_valid_i          ),
    .fetch_entry_i       ( fetch_entry_o       ),
    .fetch_entry_valid_i ( fetch_entry_valid_o ),
    .fetch_entry_ready_i ( fetch_entry_ready_i )
);

/* verification/fetch_frontend_tb.sv */
module fetch_frontend_tb;
    import fetch_pkg::*;

    localparam int     WAIT_LIMIT = 200;
    localparam addr_t  BOOT_ADDR  = 32'h0000_1000;
    // jalr x0, 0(x1)
    localparam instr_t JALR_X1    = {12'd0, 5'd1, 3'b000, 5'd0, 7'b1100111};

    logic         clk_i;
    logic         rst_ni;
    addr_t        boot_addr_i;
    logic         imem_req_o;
    addr_t        imem_addr_o;
    logic         imem_gnt_i;
    logic         imem_rvalid_i;
    instr_t       imem_rdata_i;
    resolve_t     resolve_i;
    logic         eret_i;
    addr_t        epc_i;
    logic         ex_valid_i;
    addr_t        trap_vector_i;
    fetch_entry_t fetch_entry_o;
    logic         fetch_entry_valid_o;
    logic         fetch_entry_ready_i;

    fetch_frontend dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // program image and encoders
    // --------------------------------------------------
    function automatic instr_t jal_word(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
    endfunction

    // beq x1, x2, off
    function automatic instr_t branch_word(input logic [12:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic instr_t program_word(input addr_t addr);
        case (addr)
            32'h2000: return jal_word(21'h000100);
            // backward loop to 0x3000
            32'h3008: return branch_word(13'h1ff8);
            32'h4000: return branch_word(13'h0020);
            32'h5000: return JALR_X1;
            // op-imm filler that folds in every address bit
            default:  return {addr[31:7] ^ {addr[6:0], 18'd0}, 7'b0010011};
        endcase
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // --------------------------------------------------
    // memory model with random grant delay and read latency
    // --------------------------------------------------
    initial begin : memory_model
        logic [31:0] rng;
        logic        pending;
        addr_t       pend_addr;
        int unsigned lat_cnt;
        int unsigned gnt_cnt;
        rng           = 32'h8715_b07c;
        pending       = 1'b0;
        pend_addr     = '0;
        lat_cnt       = 0;
        gnt_cnt       = 0;
        imem_gnt_i    = 1'b0;
        imem_rvalid_i = 1'b0;
        imem_rdata_i  = '0;
        forever begin
            @(negedge clk_i);
            imem_gnt_i    = 1'b0;
            imem_rvalid_i = 1'b0;
            if (!rst_ni) begin
                pending = 1'b0;
                gnt_cnt = 0;
            end else if (pending) begin
                // answer comes at least one cycle after the grant
                if (lat_cnt == 0) begin
                    imem_rvalid_i = 1'b1;
                    imem_rdata_i  = program_word(pend_addr);
                    pending       = 1'b0;
                end else begin
                    lat_cnt--;
                end
            end else if (imem_req_o) begin
                if (gnt_cnt == 0) begin
                    imem_gnt_i = 1'b1;
                    pend_addr  = imem_addr_o;
                    pending    = 1'b1;
                    rng        = xorshift32(rng);
                    lat_cnt    = rng % 3;
                    rng        = xorshift32(rng);
                    gnt_cnt    = rng % 3;
                end else begin
                    gnt_cnt--;
                end
            end
        end
    end

    // --------------------------------------------------
    // check helpers
    // --------------------------------------------------
    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected %h got %h", $time, what, expected, actual);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    // all helpers start and end on a falling edge
    task automatic wait_valid();
        int n;
        n = 0;
        while (!fetch_entry_valid_o) begin
            if (n == WAIT_LIMIT) begin
                fail_now("timeout waiting for a fetch entry");
            end
            @(negedge clk_i);
            n++;
        end
    endtask

    // takes the head with ready high for exactly that transfer
    task automatic next_entry(output fetch_entry_t e);
        wait_valid();
        e = fetch_entry_o;
        fetch_entry_ready_i = 1'b1;
        @(negedge clk_i);
        fetch_entry_ready_i = 1'b0;
    endtask

    task automatic expect_entry(input addr_t pc, input cf_e cf, input logic taken,
                                input addr_t pred);
        fetch_entry_t e;
        next_entry(e);
        check_eq(e.pc, pc, "entry pc");
        check_eq(e.instr, program_word(pc), "entry instr");
        check_eq(32'(e.cf), 32'(cf), "entry cf");
        check_eq(32'(e.taken), 32'(taken), "entry taken");
        check_eq(e.predict_addr, pred, "entry predict_addr");
    endtask

    // straight-line run
    task automatic expect_seq(input addr_t start, input int n);
        for (int i = 0; i < n; i++) begin
            expect_entry(start + addr_t'(4 * i), CF_NONE, 1'b0, start + addr_t'(4 * i + 4));
        end
    endtask

    function automatic resolve_t build_resolve(input addr_t pc, input addr_t target,
                                               input cf_e cf, input logic taken,
                                               input logic mispredict);
        resolve_t r;
        r.valid      = 1'b1;
        r.pc         = pc;
        r.target     = target;
        r.cf         = cf;
        r.taken      = taken;
        r.mispredict = mispredict;
        return r;
    endfunction

    task automatic pulse_inputs(input logic ex, input logic er, input resolve_t res);
        ex_valid_i = ex;
        eret_i     = er;
        resolve_i  = res;
        @(negedge clk_i);
        ex_valid_i = 1'b0;
        eret_i     = 1'b0;
        resolve_i  = '0;
    endtask

    // queue must be empty right after any redirect
    task automatic apply_redirect(input logic ex, input logic er, input resolve_t res);
        pulse_inputs(ex, er, res);
        check_eq(32'(fetch_entry_valid_o), 32'd0, "valid after redirect");
    endtask

    task automatic trap_to(input addr_t addr);
        trap_vector_i = addr;
        apply_redirect(1'b1, 1'b0, '0);
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic sequential_fetch();
        check_eq(32'(fetch_entry_valid_o), 32'd0, "valid after reset");
        expect_seq(BOOT_ADDR, 6);
    endtask

    task automatic back_pressure();
        trap_to(32'h1800);
        wait_valid();
        // queue fills while ready stays low
        repeat (30) @(negedge clk_i);
        check_eq(fetch_entry_o.pc, 32'h1800, "head pc under back-pressure");
        expect_seq(32'h1800, 8);
    endtask

    task automatic static_prediction();
        trap_to(32'h2000);
        expect_entry(32'h2000, CF_JUMP, 1'b1, 32'h2100);
        expect_seq(32'h2100, 2);
        trap_to(32'h3000);
        expect_seq(32'h3000, 2);
        expect_entry(32'h3008, CF_BRANCH, 1'b1, 32'h3000);
        expect_seq(32'h3000, 1);
        trap_to(32'h4000);
        expect_entry(32'h4000, CF_BRANCH, 1'b0, 32'h4004);
        expect_seq(32'h4004, 1);
    endtask

    task automatic history_training();
        pulse_inputs(1'b0, 1'b0, build_resolve(32'h4000, 32'h4020, CF_BRANCH, 1'b1, 1'b0));
        trap_to(32'h4000);
        expect_entry(32'h4000, CF_BRANCH, 1'b1, 32'h4020);
        expect_seq(32'h4020, 1);
        // counter 2 down to 0
        pulse_inputs(1'b0, 1'b0, build_resolve(32'h4000, 32'h4004, CF_BRANCH, 1'b0, 1'b0));
        pulse_inputs(1'b0, 1'b0, build_resolve(32'h4000, 32'h4004, CF_BRANCH, 1'b0, 1'b0));
        trap_to(32'h4000);
        expect_entry(32'h4000, CF_BRANCH, 1'b0, 32'h4004);
        expect_seq(32'h4004, 1);
    endtask

    task automatic target_buffer();
        trap_to(32'h5000);
        expect_entry(32'h5000, CF_JALR, 1'b0, 32'h5004);
        expect_seq(32'h5004, 1);
        // mispredict resolve trains the btb and redirects
        apply_redirect(1'b0, 1'b0, build_resolve(32'h5000, 32'h6000, CF_JALR, 1'b1, 1'b1));
        expect_seq(32'h6000, 2);
        trap_to(32'h5000);
        expect_entry(32'h5000, CF_JALR, 1'b1, 32'h6000);
        expect_seq(32'h6000, 1);
    endtask

    task automatic redirect_priority();
        trap_to(32'h7000);
        expect_seq(32'h7000, 2);
        epc_i = 32'h7100;
        apply_redirect(1'b0, 1'b1, '0);
        expect_seq(32'h7100, 2);
        apply_redirect(1'b0, 1'b0, build_resolve(32'h7a00, 32'h7200, CF_NONE, 1'b1, 1'b1));
        expect_seq(32'h7200, 2);
        // all three at once and the exception wins
        trap_vector_i = 32'h7300;
        epc_i         = 32'h7400;
        apply_redirect(1'b1, 1'b1, build_resolve(32'h7a00, 32'h7500, CF_NONE, 1'b1, 1'b1));
        expect_seq(32'h7300, 3);
    endtask

    initial begin
        rst_ni              = 1'b0;
        boot_addr_i         = BOOT_ADDR;
        resolve_i           = '0;
        eret_i              = 1'b0;
        epc_i               = '0;
        ex_valid_i          = 1'b0;
        trap_vector_i       = '0;
        fetch_entry_ready_i = 1'b0;
        repeat (5) @(negedge clk_i);
        check_eq(32'(imem_req_o), 32'd0, "imem_req_o in reset");
        rst_ni = 1'b1;
        sequential_fetch();
        back_pressure();
        static_prediction();
        history_training();
        target_buffer();
        redirect_priority();
        $display("All tests passed");
        $finish;
    end

endmodule

/* frontend_lite.f */
+incdir+logic
logic/fetch_pkg.sv
logic/fetch_ctrl.sv
logic/instr_scan.sv
logic/branch_predictor.sv
logic/fetch_queue.sv
logic/fetch_frontend.sv
verification/fetch_frontend_sva.sv
verification/fetch_frontend_tb.sv

/* Makefile */
# Verilator flow for the fetch frontend

VERILATOR ?= verilator
TOP       ?= fetch_frontend_tb
FILELIST  ?= frontend_lite.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Some tests failed
PASS_MSG  ?= All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q -e "$(FAIL_MSG)" -e "%Error" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
